// ==== include/mmiox_params.svh ====
/*
 * Bus widths, FIFO depth and the config reset value of the MMIO interface
 */

`ifndef MMIOX_PARAMS_SVH
`define MMIOX_PARAMS_SVH

// ******************************
// APB side
// ******************************
`define MMIOX_BW_APB_DATA 32
`define MMIOX_BW_OFFSET 8

// ******************************
// Core side words
// ******************************
`define MMIOX_BW_CONFIG 32
`define MMIOX_BW_STATUS 32
`define MMIOX_BW_INST 64
`define MMIOX_BW_DATA 32
`define MMIOX_BW_LOG 32

// Shared by all four queues
`define MMIOX_FIFO_DEPTH 4

// Value loaded into the config register by reset
`define MMIOX_CONFIG_DEFAULT 0

`endif

// ==== design/mmiox_reg_pkg.sv ====
/*
 * Register map: APB word and offset types, register offsets, interrupt bits
 */

`include "mmiox_params.svh"

package mmiox_reg_pkg;

  typedef logic [`MMIOX_BW_APB_DATA-1:0] apb_word_t;
  typedef logic [`MMIOX_BW_OFFSET-1:0] reg_offset_t;

  // Byte offsets within the block
  localparam reg_offset_t REG_CONFIG      = 'h00;
  localparam reg_offset_t REG_STATUS      = 'h04;
  localparam reg_offset_t REG_CLEAR       = 'h08;
  localparam reg_offset_t REG_LOG_POP     = 'h0C;
  localparam reg_offset_t REG_INST_LO     = 'h10;
  localparam reg_offset_t REG_INST_HI     = 'h14;
  localparam reg_offset_t REG_INPUT_PUSH  = 'h18;
  localparam reg_offset_t REG_OUTPUT_POP  = 'h1C;
  localparam reg_offset_t REG_FIFO_LEVEL  = 'h20;
  localparam reg_offset_t REG_ITR_ENABLE  = 'h24;
  localparam reg_offset_t REG_ITR_PENDING = 'h28;
  localparam reg_offset_t REG_OP_COUNT    = 'h2C;

  // Interrupt bit positions in the enable and pending registers
  localparam int ITR_OP_DONE    = 0;
  localparam int ITR_CLEAR_DONE = 1;

endpackage

// ==== design/mmiox_core_pkg.sv ====
/*
 * Core-side word types, FIFO level type and clear FSM states
 */

`include "mmiox_params.svh"

package mmiox_core_pkg;

  typedef logic [`MMIOX_BW_CONFIG-1:0] config_t;
  typedef logic [`MMIOX_BW_STATUS-1:0] status_t;
  typedef logic [`MMIOX_BW_INST-1:0] inst_t;
  typedef logic [`MMIOX_BW_DATA-1:0] data_t;
  typedef logic [`MMIOX_BW_LOG-1:0] log_t;

  // Holds 0 up to a full FIFO
  typedef logic [$clog2(`MMIOX_FIFO_DEPTH+1)-1:0] fifo_level_t;

  typedef enum logic [1:0] {
    CLR_IDLE,
    CLR_REQUEST,
    CLR_WAIT
  } clear_state_t;

endpackage

// ==== design/mmiox_fifo.sv ====
/*
 * Synchronous show-ahead FIFO with flush and fill level
 */

`include "mmiox_params.svh"

module mmiox_fifo #(
  parameter int DEPTH = `MMIOX_FIFO_DEPTH,
  parameter int W = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic push,
  input  logic [W-1:0] wdata,
  input  logic pop,
  output logic [W-1:0] rdata,
  output logic full,
  output logic empty,
  output mmiox_core_pkg::fifo_level_t level
);
  import mmiox_core_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [W-1:0] mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  fifo_level_t count;
  logic do_push;
  logic do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Requests against a full or empty queue are dropped here
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + fifo_level_t'(do_push) - fifo_level_t'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  assign rdata = mem[rd_ptr];
  assign full  = (count == fifo_level_t'(DEPTH));
  assign empty = (count == '0);
  assign level = count;

endmodule

// ==== design/mmiox_clear_fsm.sv ====
/*
 * Clear sequencer: flushes all queues once, then holds the request to the
 * core until it reports completion
 */

module mmiox_clear_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic clear_finish,
  output logic clear_request,
  output logic flush,
  output logic busy,
  output logic clear_done
);
  import mmiox_core_pkg::*;

  clear_state_t state;
  clear_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      CLR_IDLE: begin
        if (start) state_next = CLR_REQUEST;
      end
      // Spends a single cycle flushing the queues
      CLR_REQUEST: begin
        state_next = CLR_WAIT;
      end
      CLR_WAIT: begin
        if (clear_finish) state_next = CLR_IDLE;
      end
      default: begin
        state_next = CLR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CLR_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign flush         = (state == CLR_REQUEST);
  assign clear_request = (state == CLR_WAIT);
  assign busy          = (state != CLR_IDLE);

  // Pulses in the cycle the core first reports completion
  assign clear_done = (state == CLR_WAIT) && clear_finish;

endmodule

// ==== design/mmiox_event_counter.sv ====
/*
 * Finished-operation counter, interrupt pending bits and irq output
 */

module mmiox_event_counter (
  input  logic clk,
  input  logic rst,
  input  logic operation_finish,
  input  logic clear_done,
  input  mmiox_reg_pkg::apb_word_t itr_enable,
  input  mmiox_reg_pkg::apb_word_t pending_clear,
  input  logic pending_clear_en,
  output mmiox_reg_pkg::apb_word_t pending,
  output mmiox_reg_pkg::apb_word_t op_count,
  output logic irq
);
  import mmiox_reg_pkg::*;

  apb_word_t set_bits;
  apb_word_t clr_mask;

  always_comb begin
    set_bits = '0;
    set_bits[ITR_OP_DONE] = operation_finish;
    set_bits[ITR_CLEAR_DONE] = clear_done;
  end

  assign clr_mask = pending_clear_en ? pending_clear : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending  <= '0;
      op_count <= '0;
    end else begin
      // A new event wins over a clear of the same bit
      pending  <= (pending & ~clr_mask) | set_bits;
      op_count <= op_count + apb_word_t'(operation_finish);
    end
  end

  assign irq = |(pending & itr_enable);

endmodule

// ==== design/mmiox_apb_regs.sv ====
/*
 * APB slave: offset decode, config/enable/instruction-low registers,
 * read mux, error flag and FIFO push and pop strobes
 */

`include "mmiox_params.svh"

module mmiox_apb_regs (
  input  logic clk,
  input  logic rst,
  input  logic psel,
  input  logic penable,
  input  mmiox_reg_pkg::reg_offset_t paddr,
  input  logic pwrite,
  input  mmiox_reg_pkg::apb_word_t pwdata,
  output mmiox_reg_pkg::apb_word_t prdata,
  output logic pready,
  output logic pslverr,
  output mmiox_core_pkg::config_t core_config,
  output logic clear_start,
  output mmiox_reg_pkg::apb_word_t itr_enable,
  output mmiox_reg_pkg::apb_word_t pending_clear,
  output logic pending_clear_en,
  output logic inst_push,
  output mmiox_core_pkg::inst_t inst_wdata,
  output logic input_push,
  output mmiox_core_pkg::data_t input_wdata,
  output logic output_pop,
  output logic log_pop,
  input  mmiox_core_pkg::status_t core_status,
  input  logic clear_busy,
  input  mmiox_reg_pkg::apb_word_t pending,
  input  mmiox_reg_pkg::apb_word_t op_count,
  input  logic inst_full,
  input  logic input_full,
  input  logic output_empty,
  input  logic log_empty,
  input  mmiox_core_pkg::fifo_level_t inst_level,
  input  mmiox_core_pkg::fifo_level_t input_level,
  input  mmiox_core_pkg::fifo_level_t output_level,
  input  mmiox_core_pkg::fifo_level_t log_level,
  input  mmiox_core_pkg::data_t output_rdata,
  input  mmiox_core_pkg::log_t log_rdata
);
  import mmiox_reg_pkg::*;
  import mmiox_core_pkg::*;

  logic access;
  logic cfg_we;
  logic enable_we;
  logic inst_lo_we;
  apb_word_t inst_lo;

  // Every access ends in its first access-phase cycle
  assign access = psel && penable;
  assign pready = access;

  // ******************************
  // Decode and read mux
  // ******************************
  always_comb begin
    prdata = '0;
    pslverr = 1'b0;
    cfg_we = 1'b0;
    enable_we = 1'b0;
    inst_lo_we = 1'b0;
    clear_start = 1'b0;
    pending_clear_en = 1'b0;
    inst_push = 1'b0;
    input_push = 1'b0;
    output_pop = 1'b0;
    log_pop = 1'b0;
    if (access) begin
      case (paddr)
        REG_CONFIG: begin
          if (pwrite) cfg_we = 1'b1;
          else prdata = apb_word_t'(core_config);
        end
        REG_STATUS: begin
          if (!pwrite) prdata = apb_word_t'(core_status);
        end
        REG_CLEAR: begin
          if (!pwrite) prdata = apb_word_t'(clear_busy);
          else if (pwdata[0] && clear_busy) pslverr = 1'b1;
          else if (pwdata[0]) clear_start = 1'b1;
        end
        REG_LOG_POP: begin
          if (!pwrite && log_empty) pslverr = 1'b1;
          else if (!pwrite) begin
            prdata = apb_word_t'(log_rdata);
            log_pop = 1'b1;
          end
        end
        REG_INST_LO: begin
          if (pwrite) inst_lo_we = 1'b1;
        end
        // High half completes the instruction
        REG_INST_HI: begin
          if (pwrite && inst_full) pslverr = 1'b1;
          else if (pwrite) inst_push = 1'b1;
        end
        REG_INPUT_PUSH: begin
          if (pwrite && input_full) pslverr = 1'b1;
          else if (pwrite) input_push = 1'b1;
        end
        REG_OUTPUT_POP: begin
          if (!pwrite && output_empty) pslverr = 1'b1;
          else if (!pwrite) begin
            prdata = apb_word_t'(output_rdata);
            output_pop = 1'b1;
          end
        end
        REG_FIFO_LEVEL: begin
          if (!pwrite) begin
            prdata = {8'(log_level), 8'(output_level), 8'(input_level), 8'(inst_level)};
          end
        end
        REG_ITR_ENABLE: begin
          if (pwrite) enable_we = 1'b1;
          else prdata = itr_enable;
        end
        REG_ITR_PENDING: begin
          if (pwrite) pending_clear_en = 1'b1;
          else prdata = pending;
        end
        REG_OP_COUNT: begin
          if (!pwrite) prdata = op_count;
        end
        default: begin
          pslverr = 1'b1;
        end
      endcase
    end
  end

  // ******************************
  // Registers
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      core_config <= config_t'(`MMIOX_CONFIG_DEFAULT);
      itr_enable  <= '0;
    end else begin
      if (cfg_we) core_config <= config_t'(pwdata);
      if (enable_we) itr_enable <= pwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_lo_we) inst_lo <= pwdata;
  end

  assign inst_wdata    = inst_t'({pwdata, inst_lo});
  assign input_wdata   = data_t'(pwdata);
  assign pending_clear = pwdata;

endmodule

// ==== design/mmiox_interface.sv ====
/*
 * MMIO interface top: APB register file, clear FSM, event counter, four FIFOs
 */

`include "mmiox_params.svh"

module mmiox_interface (
  input  logic clk,
  input  logic rst,
  input  logic psel,
  input  logic penable,
  input  mmiox_reg_pkg::reg_offset_t paddr,
  input  logic pwrite,
  input  mmiox_reg_pkg::apb_word_t pwdata,
  output mmiox_reg_pkg::apb_word_t prdata,
  output logic pready,
  output logic pslverr,
  output logic irq,
  output mmiox_core_pkg::config_t core_config,
  input  mmiox_core_pkg::status_t core_status,
  output logic clear_request,
  input  logic clear_finish,
  output logic inst_rready,
  output mmiox_core_pkg::inst_t inst_rdata,
  input  logic inst_rrequest,
  output logic input_rready,
  output mmiox_core_pkg::data_t input_rdata,
  input  logic input_rrequest,
  output logic output_wready,
  input  logic output_wrequest,
  input  mmiox_core_pkg::data_t output_wdata,
  output logic log_wready,
  input  logic log_wrequest,
  input  mmiox_core_pkg::log_t log_wdata,
  input  logic operation_finish
);
  import mmiox_reg_pkg::*;
  import mmiox_core_pkg::*;

  logic clear_start;
  logic clear_busy;
  logic clear_done;
  logic flush;
  apb_word_t itr_enable;
  apb_word_t pending_clear;
  logic pending_clear_en;
  apb_word_t pending;
  apb_word_t op_count;

  logic inst_push;
  inst_t inst_wdata;
  logic inst_full;
  logic inst_empty;
  fifo_level_t inst_level;
  logic input_push;
  data_t input_wdata;
  logic input_full;
  logic input_empty;
  fifo_level_t input_level;
  logic output_pop;
  data_t output_rdata;
  logic output_full;
  logic output_empty;
  fifo_level_t output_level;
  logic log_pop;
  log_t log_rdata;
  logic log_full;
  logic log_empty;
  fifo_level_t log_level;

  // Core-side ready levels
  assign inst_rready   = !inst_empty;
  assign input_rready  = !input_empty;
  assign output_wready = !output_full;
  assign log_wready    = !log_full;

  mmiox_apb_regs apb_regs (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .paddr(paddr),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .core_config(core_config), .clear_start(clear_start),
    .itr_enable(itr_enable), .pending_clear(pending_clear),
    .pending_clear_en(pending_clear_en), .inst_push(inst_push),
    .inst_wdata(inst_wdata), .input_push(input_push), .input_wdata(input_wdata),
    .output_pop(output_pop), .log_pop(log_pop), .core_status(core_status),
    .clear_busy(clear_busy), .pending(pending), .op_count(op_count),
    .inst_full(inst_full), .input_full(input_full), .output_empty(output_empty),
    .log_empty(log_empty), .inst_level(inst_level), .input_level(input_level),
    .output_level(output_level), .log_level(log_level),
    .output_rdata(output_rdata), .log_rdata(log_rdata)
  );

  mmiox_clear_fsm clear_fsm (
    .clk(clk), .rst(rst), .start(clear_start), .clear_finish(clear_finish),
    .clear_request(clear_request), .flush(flush), .busy(clear_busy),
    .clear_done(clear_done)
  );

  mmiox_event_counter event_counter (
    .clk(clk), .rst(rst), .operation_finish(operation_finish),
    .clear_done(clear_done), .itr_enable(itr_enable),
    .pending_clear(pending_clear), .pending_clear_en(pending_clear_en),
    .pending(pending), .op_count(op_count), .irq(irq)
  );

  // ******************************
  // Queues, processor to core
  // ******************************
  mmiox_fifo #(.DEPTH(`MMIOX_FIFO_DEPTH), .W(`MMIOX_BW_INST)) inst_fifo (
    .clk(clk), .rst(rst), .flush(flush), .push(inst_push), .wdata(inst_wdata),
    .pop(inst_rrequest), .rdata(inst_rdata), .full(inst_full),
    .empty(inst_empty), .level(inst_level)
  );

  mmiox_fifo #(.DEPTH(`MMIOX_FIFO_DEPTH), .W(`MMIOX_BW_DATA)) input_fifo (
    .clk(clk), .rst(rst), .flush(flush), .push(input_push), .wdata(input_wdata),
    .pop(input_rrequest), .rdata(input_rdata), .full(input_full),
    .empty(input_empty), .level(input_level)
  );

  // ******************************
  // Queues, core to processor
  // ******************************
  mmiox_fifo #(.DEPTH(`MMIOX_FIFO_DEPTH), .W(`MMIOX_BW_DATA)) output_fifo (
    .clk(clk), .rst(rst), .flush(flush), .push(output_wrequest),
    .wdata(output_wdata), .pop(output_pop), .rdata(output_rdata),
    .full(output_full), .empty(output_empty), .level(output_level)
  );

  mmiox_fifo #(.DEPTH(`MMIOX_FIFO_DEPTH), .W(`MMIOX_BW_LOG)) log_fifo (
    .clk(clk), .rst(rst), .flush(flush), .push(log_wrequest), .wdata(log_wdata),
    .pop(log_pop), .rdata(log_rdata), .full(log_full), .empty(log_empty),
    .level(log_level)
  );

endmodule

// ==== tests/mmiox_interface_tb.sv ====
/*
 * Random-stimulus testbench for the MMIO interface with a queue-based model,
 * typed compare tasks and a cycle limit
 */

`include "mmiox_params.svh"

module mmiox_interface_tb;
  import mmiox_reg_pkg::*;
  import mmiox_core_pkg::*;

  localparam int N_CFG = 16;
  localparam int N_QUEUE = 80;
  localparam int N_OUT = 80;
  localparam int N_ITR = 40;
  localparam int TRANSACTIONS = 4 + 4*N_CFG + 3*N_QUEUE + 2*N_OUT + 30 + 3*N_ITR;
  localparam int CYCLE_LIMIT = 20 * TRANSACTIONS;

  // Core request mask bits
  localparam logic [4:0] M_POPS = 5'b00011;
  localparam logic [4:0] M_PUSHES = 5'b01100;
  localparam logic [4:0] M_FINISH = 5'b10000;

  logic clk;
  logic rst;
  logic psel;
  logic penable;
  reg_offset_t paddr;
  logic pwrite;
  apb_word_t pwdata;
  apb_word_t prdata;
  logic pready;
  logic pslverr;
  logic irq;
  config_t core_config;
  status_t core_status;
  logic clear_request;
  logic clear_finish;
  logic inst_rready;
  inst_t inst_rdata;
  logic inst_rrequest;
  logic input_rready;
  data_t input_rdata;
  logic input_rrequest;
  logic output_wready;
  logic output_wrequest;
  data_t output_wdata;
  logic log_wready;
  logic log_wrequest;
  log_t log_wdata;
  logic operation_finish;

  // Reference model state
  inst_t q_inst[$];
  data_t q_input[$];
  data_t q_output[$];
  log_t q_log[$];
  config_t m_config;
  apb_word_t m_enable;
  apb_word_t m_pending;
  apb_word_t m_op_count;

  logic [31:0] lfsr_state = 32'h4ec2_f9d3;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  mmiox_interface mmiox_interface_i (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .paddr(paddr),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .irq(irq), .core_config(core_config),
    .core_status(core_status), .clear_request(clear_request),
    .clear_finish(clear_finish), .inst_rready(inst_rready),
    .inst_rdata(inst_rdata), .inst_rrequest(inst_rrequest),
    .input_rready(input_rready), .input_rdata(input_rdata),
    .input_rrequest(input_rrequest), .output_wready(output_wready),
    .output_wrequest(output_wrequest), .output_wdata(output_wdata),
    .log_wready(log_wready), .log_wrequest(log_wrequest), .log_wdata(log_wdata),
    .operation_finish(operation_finish)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // Steps once per bit taken with taps 32, 22, 2 and 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_word(input string name, input apb_word_t got, input apb_word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input fifo_level_t got,
                             input fifo_level_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // ******************************
  // APB accesses
  // ******************************
  task automatic apb_access(input reg_offset_t addr, input logic wr, input apb_word_t wdata,
                            output apb_word_t rdata, output logic err);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    paddr <= addr;
    pwrite <= wr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    check_flag("pready", pready, 1'b1);
    rdata = prdata;
    err = pslverr;
    // The access completes at this edge
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input reg_offset_t addr, input apb_word_t wdata,
                           input logic exp_err);
    apb_word_t rdata;
    logic err;
    apb_access(addr, 1'b1, wdata, rdata, err);
    check_flag("pslverr", err, exp_err);
  endtask

  task automatic apb_read(input reg_offset_t addr, input logic exp_err,
                          output apb_word_t rdata);
    logic err;
    apb_access(addr, 1'b0, '0, rdata, err);
    check_flag("pslverr", err, exp_err);
  endtask

  task automatic read_levels;
    apb_word_t r;
    apb_read(REG_FIFO_LEVEL, 1'b0, r);
    check_level("inst_level", fifo_level_t'(r[7:0]), fifo_level_t'(q_inst.size()));
    check_level("input_level", fifo_level_t'(r[15:8]), fifo_level_t'(q_input.size()));
    check_level("output_level", fifo_level_t'(r[23:16]), fifo_level_t'(q_output.size()));
    check_level("log_level", fifo_level_t'(r[31:24]), fifo_level_t'(q_log.size()));
  endtask

  task automatic push_inst;
    apb_word_t lo;
    apb_word_t hi;
    logic full;
    lo = apb_word_t'(rand_bits(32));
    hi = apb_word_t'(rand_bits(32));
    full = (q_inst.size() == `MMIOX_FIFO_DEPTH);
    apb_write(REG_INST_LO, lo, 1'b0);
    apb_write(REG_INST_HI, hi, full);
    if (!full) q_inst.push_back({hi, lo});
  endtask

  task automatic push_input;
    data_t d;
    logic full;
    d = data_t'(rand_bits(32));
    full = (q_input.size() == `MMIOX_FIFO_DEPTH);
    apb_write(REG_INPUT_PUSH, d, full);
    if (!full) q_input.push_back(d);
  endtask

  task automatic pop_output;
    apb_word_t r;
    data_t exp;
    logic empty;
    empty = (q_output.size() == 0);
    exp = '0;
    if (!empty) exp = q_output[0];
    apb_read(REG_OUTPUT_POP, empty, r);
    check_data("output_pop", data_t'(r), exp);
    if (!empty) void'(q_output.pop_front());
  endtask

  task automatic pop_log;
    apb_word_t r;
    log_t exp;
    logic empty;
    empty = (q_log.size() == 0);
    exp = '0;
    if (!empty) exp = q_log[0];
    apb_read(REG_LOG_POP, empty, r);
    check_word("log_pop", r, apb_word_t'(exp));
    if (!empty) void'(q_log.pop_front());
  endtask

  // ******************************
  // Core side
  // ******************************
  task automatic core_cycle(input logic [4:0] mask);
    logic [4:0] req;
    data_t out_d;
    log_t log_d;
    req = 5'(rand_bits(5)) & mask;
    out_d = data_t'(rand_bits(32));
    log_d = log_t'(rand_bits(32));
    @(posedge clk);
    inst_rrequest <= req[0];
    input_rrequest <= req[1];
    output_wrequest <= req[2];
    output_wdata <= out_d;
    log_wrequest <= req[3];
    log_wdata <= log_d;
    operation_finish <= req[4];
    @(negedge clk);
    check_flag("inst_rready", inst_rready, q_inst.size() > 0);
    check_flag("input_rready", input_rready, q_input.size() > 0);
    check_flag("output_wready", output_wready, q_output.size() < `MMIOX_FIFO_DEPTH);
    check_flag("log_wready", log_wready, q_log.size() < `MMIOX_FIFO_DEPTH);
    if (req[0] && q_inst.size() > 0) begin
      check_inst("inst_rdata", inst_rdata, q_inst[0]);
      void'(q_inst.pop_front());
    end
    if (req[1] && q_input.size() > 0) begin
      check_data("input_rdata", input_rdata, q_input[0]);
      void'(q_input.pop_front());
    end
    // Requests while not ready are dropped
    if (req[2] && q_output.size() < `MMIOX_FIFO_DEPTH) q_output.push_back(out_d);
    if (req[3] && q_log.size() < `MMIOX_FIFO_DEPTH) q_log.push_back(log_d);
    if (req[4]) begin
      m_op_count++;
      m_pending[ITR_OP_DONE] = 1'b1;
    end
    @(posedge clk);
    inst_rrequest <= 1'b0;
    input_rrequest <= 1'b0;
    output_wrequest <= 1'b0;
    log_wrequest <= 1'b0;
    operation_finish <= 1'b0;
  endtask

  task automatic wait_request(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (clear_request !== level && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (clear_request !== level) begin
      $display("clear_request did not reach %b within 20 cycles at %0t", level, $time);
      errors++;
    end
  endtask

  task automatic check_irq;
    @(negedge clk);
    check_flag("irq", irq, |(m_pending & m_enable));
  endtask

  // ******************************
  // Test sequence
  // ******************************
  initial begin
    apb_word_t r;
    apb_word_t v;
    status_t s;
    logic [2:0] op;
    int delay;

    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    paddr = '0;
    pwrite = 1'b0;
    pwdata = '0;
    core_status = '0;
    clear_finish = 1'b0;
    inst_rrequest = 1'b0;
    input_rrequest = 1'b0;
    output_wrequest = 1'b0;
    output_wdata = '0;
    log_wrequest = 1'b0;
    log_wdata = '0;
    operation_finish = 1'b0;
    m_config = config_t'(`MMIOX_CONFIG_DEFAULT);
    m_enable = '0;
    m_pending = '0;
    m_op_count = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    @(negedge clk);
    check_flag("irq", irq, 1'b0);
    check_flag("inst_rready", inst_rready, 1'b0);
    check_flag("input_rready", input_rready, 1'b0);
    check_flag("output_wready", output_wready, 1'b1);
    check_flag("log_wready", log_wready, 1'b1);
    apb_read(REG_CONFIG, 1'b0, r);
    check_word("config", r, m_config);
    read_levels;
    apb_read(reg_offset_t'('h30), 1'b1, r);

    // Config and status
    for (int i = 0; i < N_CFG; i++) begin
      v = apb_word_t'(rand_bits(32));
      apb_write(REG_CONFIG, v, 1'b0);
      m_config = config_t'(v);
      @(negedge clk);
      check_word("core_config", core_config, m_config);
      s = status_t'(rand_bits(32));
      @(posedge clk);
      core_status <= s;
      apb_read(REG_STATUS, 1'b0, r);
      check_word("status", r, s);
      apb_read(REG_CONFIG, 1'b0, r);
      check_word("config", r, m_config);
    end

    // Processor to core queues fill up since pushes outpace pops
    for (int i = 0; i < N_QUEUE; i++) begin
      op = 3'(rand_bits(2));
      case (op)
        3'd0: push_inst;
        3'd1: push_input;
        3'd2: core_cycle(M_POPS);
        default: read_levels;
      endcase
    end

    // Core to processor queues
    pop_output;
    pop_log;
    for (int i = 0; i < N_OUT; i++) begin
      op = 3'(rand_bits(3));
      if (op < 3'd4) core_cycle(M_PUSHES);
      else if (op == 3'd4) pop_output;
      else if (op == 3'd5) pop_log;
      else read_levels;
    end

    // Clear handshake
    push_input;
    apb_write(REG_CLEAR, 32'h1, 1'b0);
    q_inst.delete();
    q_input.delete();
    q_output.delete();
    q_log.delete();
    wait_request(1'b1);
    apb_read(REG_CLEAR, 1'b0, r);
    check_word("clear_busy", r, 32'h1);
    apb_write(REG_CLEAR, 32'h1, 1'b1);
    read_levels;
    delay = int'(rand_bits(4));
    repeat (delay) begin
      @(negedge clk);
      check_flag("clear_request", clear_request, 1'b1);
    end
    @(posedge clk);
    clear_finish <= 1'b1;
    // Still requesting in the cycle the core reports completion
    @(negedge clk);
    check_flag("clear_request", clear_request, 1'b1);
    @(posedge clk);
    clear_finish <= 1'b0;
    wait_request(1'b0);
    m_pending[ITR_CLEAR_DONE] = 1'b1;
    apb_read(REG_ITR_PENDING, 1'b0, r);
    check_word("pending", r, m_pending);
    apb_read(REG_CLEAR, 1'b0, r);
    check_word("clear_busy", r, 32'h0);
    read_levels;
    @(negedge clk);
    check_flag("inst_rready", inst_rready, 1'b0);
    check_flag("input_rready", input_rready, 1'b0);

    // Interrupts and operation count
    for (int i = 0; i < N_ITR; i++) begin
      op = 3'(rand_bits(2));
      case (op)
        3'd0: core_cycle(M_FINISH);
        3'd1: begin
          m_enable = apb_word_t'(rand_bits(32));
          apb_write(REG_ITR_ENABLE, m_enable, 1'b0);
        end
        3'd2: begin
          v = apb_word_t'(rand_bits(32));
          apb_write(REG_ITR_PENDING, v, 1'b0);
          m_pending = m_pending & ~v;
        end
        default: begin
          apb_read(REG_OP_COUNT, 1'b0, r);
          check_word("op_count", r, m_op_count);
          apb_read(REG_ITR_PENDING, 1'b0, r);
          check_word("pending", r, m_pending);
        end
      endcase
      check_irq;
    end
    apb_read(REG_OP_COUNT, 1'b0, r);
    check_word("op_count", r, m_op_count);
    apb_read(REG_ITR_ENABLE, 1'b0, r);
    check_word("itr_enable", r, m_enable);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== mmiox_interface.f ====
+incdir+include
design/mmiox_reg_pkg.sv
design/mmiox_core_pkg.sv
design/mmiox_fifo.sv
design/mmiox_clear_fsm.sv
design/mmiox_event_counter.sv
design/mmiox_apb_regs.sv
design/mmiox_interface.sv
tests/mmiox_interface_tb.sv

// ==== Bender.yml ====
package:
  name: mmiox_interface

export_include_dirs:
  - include

sources:
  - design/mmiox_reg_pkg.sv
  - design/mmiox_core_pkg.sv
  - design/mmiox_fifo.sv
  - design/mmiox_clear_fsm.sv
  - design/mmiox_event_counter.sv
  - design/mmiox_apb_regs.sv
  - design/mmiox_interface.sv
  - target: test
    files:
      - tests/mmiox_interface_tb.sv
